//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_aes_decrypt
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- src/aes_decrypt_top.sv
module aes_decrypt_top
	import aes_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [127:0] key,
	input logic [127:0] ciphertext,
	output logic busy,
	output logic done,
	output logic [127:0] plaintext
);

	logic key_load;
	logic keys_ready;
	logic [3:0] key_index;
	logic [127:0] round_key;
	logic last_round;
	aes_state_u state_reg;
	aes_state_u round_state;

	aes_key_schedule i_key_schedule (
		.clk(clk),
		.rst_n(rst_n),
		.key_load(key_load),
		.key(key),
		.key_index(key_index),
		.round_key(round_key),
		.keys_ready(keys_ready)
	);

	aes_round_control i_round_control (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ciphertext(ciphertext),
		.keys_ready(keys_ready),
		.round_key(round_key),
		.round_state(round_state),
		.key_load(key_load),
		.key_index(key_index),
		.state_reg(state_reg),
		.last_round(last_round),
		.busy(busy),
		.done(done),
		.plaintext(plaintext)
	);

	inv_round i_inv_round (
		.state_in(state_reg),
		.round_key(round_key),
		.last_round(last_round),
		.state_out(round_state)
	);

endmodule

//--- src/aes_key_schedule.sv
module aes_key_schedule
	import aes_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic key_load,
	input logic [127:0] key,
	input logic [3:0] key_index,
	output logic [127:0] round_key,
	output logic keys_ready
);

	logic [127:0] round_keys [0:NUM_ROUNDS];
	logic [3:0] exp_cnt;
	logic expanding;
	logic [127:0] prev_key;
	logic [31:0] w0;
	logic [31:0] w1;
	logic [31:0] w2;
	logic [31:0] w3;
	logic [31:0] sub_rot;
	logic [127:0] next_key;

	assign prev_key = round_keys[exp_cnt - 4'd1];
	assign {w0, w1, w2, w3} = prev_key;

	// RotWord and SubWord on the last word, then the round constant on its top byte.
	assign sub_rot = {sbox[w3[23:16]], sbox[w3[15:8]], sbox[w3[7:0]], sbox[w3[31:24]]}
		^ {rcon[exp_cnt - 4'd1], 24'h000000};

	assign next_key[127:96] = w0 ^ sub_rot;
	assign next_key[95:64] = w1 ^ next_key[127:96];
	assign next_key[63:32] = w2 ^ next_key[95:64];
	assign next_key[31:0] = w3 ^ next_key[63:32];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			exp_cnt <= 4'd0;
			expanding <= 1'b0;
			keys_ready <= 1'b0;
		end
		else if (key_load)
		begin
			exp_cnt <= 4'd1;
			expanding <= 1'b1;
			keys_ready <= 1'b0;
		end
		else if (expanding)
		begin
			if (exp_cnt == 4'(NUM_ROUNDS))
			begin
				expanding <= 1'b0;
				keys_ready <= 1'b1;
			end
			else
			begin
				exp_cnt <= exp_cnt + 4'd1;
			end
		end
	end

	// Key 0 is the cipher key itself; one more key is written each cycle after it.
	always_ff @(posedge clk)
	begin
		if (key_load)
		begin
			round_keys[0] <= key;
		end
		else if (expanding)
		begin
			round_keys[exp_cnt] <= next_key;
		end
	end

	assign round_key = round_keys[key_index];

endmodule

//--- src/aes_pkg.sv
package aes_pkg;

	localparam int NUM_ROUNDS = 10;

	// Byte 0 is the most significant byte, so bytes run down each column in turn.
	typedef union packed
	{
		logic [127:0] block;
		logic [0:15][7:0] bytes;
	} aes_state_u;

	localparam logic [0:255][7:0] sbox = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] inv_sbox = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// Round constants for key expansion rounds 1 to 10.
	localparam logic [0:9][7:0] rcon = {
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// Multiply by x in GF(2^8), reducing by the AES polynomial.
	function automatic logic [7:0] gf_xtime(input logic [7:0] b);
		logic [7:0] shifted;
		shifted = {b[6:0], 1'b0};
		if (b[7])
		begin
			shifted = shifted ^ 8'h1b;
		end
		return shifted;
	endfunction

endpackage

//--- src/aes_round_control.sv
module aes_round_control
	import aes_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [127:0] ciphertext,
	input logic keys_ready,
	input logic [127:0] round_key,
	input aes_state_u round_state,
	output logic key_load,
	output logic [3:0] key_index,
	output aes_state_u state_reg,
	output logic last_round,
	output logic busy,
	output logic done,
	output logic [127:0] plaintext
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_expand = 2'd1;
	localparam logic [1:0] st_whiten = 2'd2;
	localparam logic [1:0] st_rounds = 2'd3;

	logic [1:0] fsm;
	logic [3:0] round_cnt;

	assign key_load = start && (fsm == st_idle);
	assign busy = (fsm != st_idle);
	assign key_index = (fsm == st_rounds) ? round_cnt : 4'(NUM_ROUNDS);
	assign last_round = (fsm == st_rounds) && (round_cnt == 4'd0);

	// During expansion round_cnt times the ten key cycles; in the rounds it is the key index.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fsm <= st_idle;
			round_cnt <= 4'd0;
			done <= 1'b0;
			plaintext <= 128'd0;
		end
		else
		begin
			done <= 1'b0;
			case (fsm)
				st_idle:
				begin
					if (start)
					begin
						fsm <= st_expand;
						round_cnt <= 4'(NUM_ROUNDS - 1);
					end
				end
				st_expand:
				begin
					if (round_cnt == 4'd0)
					begin
						fsm <= st_whiten;
					end
					else
					begin
						round_cnt <= round_cnt - 4'd1;
					end
				end
				st_whiten:
				begin
					if (keys_ready)
					begin
						fsm <= st_rounds;
						round_cnt <= 4'(NUM_ROUNDS - 1);
					end
				end
				default:
				begin
					if (round_cnt == 4'd0)
					begin
						fsm <= st_idle;
						done <= 1'b1;
						plaintext <= round_state.block;
					end
					else
					begin
						round_cnt <= round_cnt - 4'd1;
					end
				end
			endcase
		end
	end

	// The ciphertext waits in the state register until key 10 is ready.
	always_ff @(posedge clk)
	begin
		if (key_load)
		begin
			state_reg.block <= ciphertext;
		end
		else if (fsm == st_whiten && keys_ready)
		begin
			state_reg.block <= state_reg.block ^ round_key;
		end
		else if (fsm == st_rounds)
		begin
			state_reg <= round_state;
		end
	end

endmodule

//--- src/inv_mix_columns.sv
module inv_mix_columns
	import aes_pkg::*;
(
	input aes_state_u state_in,
	output aes_state_u state_out
);

	logic [0:15][7:0] x2;
	logic [0:15][7:0] x4;
	logic [0:15][7:0] x8;
	logic [0:15][7:0] m9;
	logic [0:15][7:0] m11;
	logic [0:15][7:0] m13;
	logic [0:15][7:0] m14;

	// The four factors share the powers of two of each byte.
	always_comb
	begin
		for (int i = 0; i < 16; i++)
		begin
			x2[i] = gf_xtime(state_in.bytes[i]);
			x4[i] = gf_xtime(x2[i]);
			x8[i] = gf_xtime(x4[i]);
			m9[i] = x8[i] ^ state_in.bytes[i];
			m11[i] = x8[i] ^ x2[i] ^ state_in.bytes[i];
			m13[i] = x8[i] ^ x4[i] ^ state_in.bytes[i];
			m14[i] = x8[i] ^ x4[i] ^ x2[i];
		end
	end

	// Rows of the matrix are rotations of {14, 11, 13, 9}.
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			state_out.bytes[4*c]   = m14[4*c] ^ m11[4*c+1] ^ m13[4*c+2] ^ m9[4*c+3];
			state_out.bytes[4*c+1] = m9[4*c] ^ m14[4*c+1] ^ m11[4*c+2] ^ m13[4*c+3];
			state_out.bytes[4*c+2] = m13[4*c] ^ m9[4*c+1] ^ m14[4*c+2] ^ m11[4*c+3];
			state_out.bytes[4*c+3] = m11[4*c] ^ m13[4*c+1] ^ m9[4*c+2] ^ m14[4*c+3];
		end
	end

endmodule

//--- src/inv_round.sv
module inv_round
	import aes_pkg::*;
(
	input aes_state_u state_in,
	input logic [127:0] round_key,
	input logic last_round,
	output aes_state_u state_out
);

	aes_state_u shifted;
	aes_state_u subbed;
	aes_state_u keyed;
	aes_state_u mixed;

	// Row r moves right by r positions; byte index is row + 4 * column.
	always_comb
	begin
		for (int r = 0; r < 4; r++)
		begin
			for (int c = 0; c < 4; c++)
			begin
				shifted.bytes[r + 4*c] = state_in.bytes[r + 4*((c + 4 - r) % 4)];
			end
		end
	end

	inv_sub_bytes i_inv_sub_bytes (
		.state_in(shifted),
		.state_out(subbed)
	);

	assign keyed.block = subbed.block ^ round_key;

	inv_mix_columns i_inv_mix_columns (
		.state_in(keyed),
		.state_out(mixed)
	);

	// The final round skips the column mix.
	assign state_out = last_round ? keyed : mixed;

endmodule

//--- src/inv_sub_bytes.sv
module inv_sub_bytes
	import aes_pkg::*;
(
	input aes_state_u state_in,
	output aes_state_u state_out
);

	// Each byte is looked up on its own, so all sixteen run in parallel.
	always_comb
	begin
		for (int i = 0; i < 16; i++)
		begin
			state_out.bytes[i] = inv_sbox[state_in.bytes[i]];
		end
	end

endmodule

//--- testbench/aes_golden.txt
# Columns: key, ciphertext, expected plaintext; each 128-bit hex, one test per line.
# Lines starting with # are skipped.
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
00000000000000000000000000000000 0336763e966d92595a567cc9ce537f5e f34481ec3cc627bacd5dc3fb08f273e6
10a58869d74be5a374cf867cfb473859 6d251e6944b051e04eaa6fb4dbf78465 00000000000000000000000000000000
00000000000000000000000000000000 a9a1631bf4996954ebc093957b234589 9798c4640bad75c7c3227db910174e72
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
00000000000000000000000000000000 ff4f8391a6a40ca5b25d23bedd44a597 96ab5c2ff612d9dfaae8c31f30c42168
80000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8 00000000000000000000000000000000
00000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 80000000000000000000000000000000
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
00000000000000000000000000000000 dc43be40be0e53712f7e2bf5ca707209 6a118a874519e64e9963798a503f1d35
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710

//--- testbench/tb_aes_decrypt.sv
module tb_aes_decrypt;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int period_ns = 20;
	localparam int reset_cycles = 3;
	localparam int latency = 21;
	localparam int input_delay = 2;
	localparam string golden_path = "testbench/aes_golden.txt";

	logic clk;
	logic rst_n;
	logic start;
	logic [127:0] key;
	logic [127:0] ciphertext;
	logic [127:0] expected;
	logic busy;
	logic done;
	logic [127:0] plaintext;
	int pass_count;
	int fail_count;
	int wait_errors;
	logic loaded;

	logic [127:0] gold_key [$];
	logic [127:0] gold_ct [$];
	logic [127:0] gold_pt [$];

	tb_clock_gen #(
		.period_ns(period_ns),
		.reset_cycles(reset_cycles)
	) i_clock_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	aes_decrypt_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.key(key),
		.ciphertext(ciphertext),
		.busy(busy),
		.done(done),
		.plaintext(plaintext)
	);

	tb_checker i_checker (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.done(done),
		.plaintext(plaintext),
		.expected(expected),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	task automatic next_cycle();
		@(posedge clk);
		#(input_delay);
	endtask

	// Lines that do not hold three hex words, such as comments, are skipped.
	task automatic load_golden();
		int fd;
		string line;
		logic [127:0] k;
		logic [127:0] c;
		logic [127:0] p;
		fd = $fopen(golden_path, "r");
		if (fd == 0)
		begin
			$display("cannot open golden file %s", golden_path);
			return;
		end
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h", k, c, p) == 3)
			begin
				gold_key.push_back(k);
				gold_ct.push_back(c);
				gold_pt.push_back(p);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		int gap;
		int hold;
		int waited;
		gap = (t % 4 == 2) ? 0 : int'($urandom_range(5, 0));
		repeat (gap) next_cycle();
		start = 1'b1;
		key = gold_key[t];
		ciphertext = gold_ct[t];
		expected = gold_pt[t];
		next_cycle();
		start = 1'b0;
		// Some tests get a second start with junk inputs while the block is running.
		if (t % 3 == 1)
		begin
			hold = int'($urandom_range(15, 1));
			repeat (hold) next_cycle();
			start = 1'b1;
			key = {$urandom(), $urandom(), $urandom(), $urandom()};
			ciphertext = {$urandom(), $urandom(), $urandom(), $urandom()};
			next_cycle();
			start = 1'b0;
		end
		waited = 0;
		while (!done && waited < latency + 10)
		begin
			next_cycle();
			waited++;
		end
		if (!done)
		begin
			$display("test %0d: timed out waiting for done", t + 1);
			wait_errors++;
		end
	endtask

	initial
	begin
		start = 1'b0;
		key = '0;
		ciphertext = '0;
		expected = '0;
		wait_errors = 0;
		loaded = 1'b0;
		void'($urandom(32'h7a1f));
		load_golden();
		loaded = 1'b1;
		wait (rst_n === 1'b1);
		next_cycle();
		next_cycle();
		for (int t = 0; t < gold_key.size(); t++)
		begin
			run_test(t);
		end
		repeat (3) next_cycle();
		$display("tests %0d, passed %0d, failed %0d",
			gold_key.size(), pass_count, fail_count + wait_errors);
		if (gold_key.size() > 0 && fail_count == 0 && wait_errors == 0
			&& pass_count == gold_key.size())
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	// Each test needs the latency, up to five idle cycles and a small margin.
	initial
	begin
		int limit_cycles;
		wait (loaded);
		limit_cycles = gold_key.size() * (latency + 5 + 4) + reset_cycles;
		#(limit_cycles * period_ns);
		$display("run timed out after %0d cycles", limit_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

//--- testbench/tb_checker.sv
module tb_checker
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic [127:0] plaintext,
	input logic [127:0] expected,
	output int pass_count,
	output int fail_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int latency = 21;

	logic in_flight;
	logic test_ok;
	int edges;
	int test_num;
	logic [127:0] want;

	task automatic close_test();
		if (edges != latency)
		begin
			$display("test %0d: done came %0d edges after start instead of %0d",
				test_num, edges, latency);
			test_ok = 1'b0;
		end
		if (busy)
		begin
			$display("test %0d: busy still high while done pulsed", test_num);
			test_ok = 1'b0;
		end
		if (plaintext !== want)
		begin
			$display("mismatch plaintext test %0d: expected %h, got %h", test_num, want, plaintext);
			test_ok = 1'b0;
		end
		else if (test_ok)
		begin
			$display("test %0d: plaintext %h correct", test_num, plaintext);
		end
		if (test_ok)
		begin
			pass_count++;
		end
		else
		begin
			fail_count++;
		end
		in_flight = 1'b0;
	endtask

	// Sampled on the falling edge, halfway between input changes and DUT updates.
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			in_flight = 1'b0;
			test_ok = 1'b1;
			edges = 0;
			test_num = 0;
			want = '0;
			pass_count = 0;
			fail_count = 0;
		end
		else
		begin
			if (in_flight)
			begin
				edges++;
				if (done)
				begin
					close_test();
				end
				else if (edges >= latency)
				begin
					$display("test %0d: no done pulse %0d edges after start", test_num, latency);
					fail_count++;
					in_flight = 1'b0;
				end
				else if (!busy && test_ok)
				begin
					$display("test %0d: busy dropped before done", test_num);
					test_ok = 1'b0;
				end
			end
			else if (done)
			begin
				$display("done pulse seen with no decryption running");
				fail_count++;
			end
			else if (busy)
			begin
				$display("busy high with no decryption running");
				fail_count++;
			end
			// A start while busy must be ignored, so only an idle start opens a test.
			if (start && !busy)
			begin
				in_flight = 1'b1;
				test_ok = 1'b1;
				edges = -1;
				want = expected;
				test_num++;
			end
		end
	end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen
#(
	parameter int period_ns = 20,
	parameter int reset_cycles = 3
)
(
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Reset is released a quarter period after the last reset edge.
	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#(period_ns / 4) rst_n = 1'b1;
	end

endmodule

//--- verilog.f
src/aes_pkg.sv
src/inv_sub_bytes.sv
src/inv_mix_columns.sv
src/inv_round.sv
src/aes_key_schedule.sv
src/aes_round_control.sv
src/aes_decrypt_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_aes_decrypt.sv
